// File: Makefile
# Verilator build and run of the group-normalization testbench
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_group_norm
FILE_LIST = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Pass or fail comes from the log, not from the simulator exit status
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
source/gn_pkg.sv
source/group_loader.sv
source/group_bank_buffer.sv
source/group_stats.sv
source/norm_emitter.sv
source/group_norm_top.sv
testbench/tb_group_norm.sv

// File: source/gn_pkg.sv
// Shared definitions for the group-normalization engine
// Lane and beat geometry of a group, bank count
// Fixed-point widths of input, sums, variance and inverse square root
// Output saturation limits
// State encoding of the statistics FSM
package gn_pkg;

    // Group geometry: 4 beats of 4 lanes
    localparam int LANES          = 4;
    localparam int BEATS          = 4;
    localparam int GROUP_SIZE     = LANES * BEATS;
    localparam int GROUP_SHIFT    = $clog2(GROUP_SIZE);
    localparam int BEAT_IDX_WIDTH = $clog2(BEATS);
    localparam int NUM_BANKS      = 2;

    // Input is Q5.2, output is Q3.4
    localparam int IN_WIDTH       = 8;
    localparam int OUT_WIDTH      = 8;
    localparam int BEAT_WIDTH     = LANES * IN_WIDTH;
    localparam int OUT_BEAT_WIDTH = LANES * OUT_WIDTH;

    // Group statistics
    localparam int SUM_WIDTH      = 12;
    localparam int SQ_WIDTH       = 18;
    // Variance in units of 1/16
    localparam int VAR_WIDTH      = 16;
    localparam int INV_WIDTH      = 12;

    // r*r*var is bounded by 2^INV_TARGET_SHIFT
    localparam int INV_TARGET_SHIFT = 20;
    localparam int NORM_SHIFT       = 10;

    localparam int OUT_MAX = 2 ** (OUT_WIDTH - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_WIDTH - 1));

    typedef enum logic [1:0] {
        S_IDLE,
        S_VAR,
        S_ROOT,
        S_HOLD
    } stats_state_t;

endpackage

// File: source/group_bank_buffer.sv
// Two-bank group buffer
// Each bank holds the four beats of one group
// Per-bank full flag, set when the loader completes a group
// and cleared when the emitter has drained it
`timescale 1ns/1ns

module group_bank_buffer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_en,
    input  logic                              wr_bank,
    input  logic [gn_pkg::BEAT_IDX_WIDTH-1:0] wr_beat,
    input  logic [gn_pkg::BEAT_WIDTH-1:0]     wr_data,
    input  logic                              fill_done,
    input  logic                              rd_bank,
    input  logic [gn_pkg::BEAT_IDX_WIDTH-1:0] rd_beat,
    output logic [gn_pkg::BEAT_WIDTH-1:0]     rd_data,
    input  logic                              drain_done,
    output logic [gn_pkg::NUM_BANKS-1:0]      bank_free
);
    import gn_pkg::*;

    logic [BEAT_WIDTH-1:0] mem [NUM_BANKS][BEATS];
    logic [NUM_BANKS-1:0]  full;

    assign bank_free = ~full;

    // Read port is combinational, the emitter registers the result
    assign rd_data = mem[rd_bank][rd_beat];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_beat] <= wr_data;
        end
    end

    // Fill and drain never target the same bank in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            full <= '0;
        end else begin
            if (fill_done) begin
                full[wr_bank] <= 1'b1;
            end
            if (drain_done) begin
                full[rd_bank] <= 1'b0;
            end
        end
    end

endmodule

// File: source/group_loader.sv
// Input side of the group-normalization engine
// Accepts beats, writes them to a free buffer bank,
// accumulates the group sum and sum of squares
// and offers the totals once per group
`timescale 1ns/1ns

module group_loader (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [gn_pkg::BEAT_WIDTH-1:0]       in_data,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  logic [gn_pkg::NUM_BANKS-1:0]        bank_free,
    output logic                                wr_en,
    output logic                                wr_bank,
    output logic [gn_pkg::BEAT_IDX_WIDTH-1:0]   wr_beat,
    output logic [gn_pkg::BEAT_WIDTH-1:0]       wr_data,
    output logic                                fill_done,
    output logic signed [gn_pkg::SUM_WIDTH-1:0] sum_data,
    output logic [gn_pkg::SQ_WIDTH-1:0]         sq_data,
    output logic                                sums_valid,
    input  logic                                sums_ready,
    output logic                                stats_bank
);
    import gn_pkg::*;

    logic [BEAT_IDX_WIDTH-1:0]  beat_cnt;
    logic                       cur_bank;
    logic                       pick_bank;
    logic                       last_beat;
    logic signed [IN_WIDTH-1:0] lane;
    logic [2*IN_WIDTH-1:0]      lane_sq;
    logic signed [SUM_WIDTH-1:0] beat_sum;
    logic [SQ_WIDTH-1:0]        beat_sq;
    logic signed [SUM_WIDTH-1:0] acc_sum;
    logic [SQ_WIDTH-1:0]        acc_sq;
    logic signed [SUM_WIDTH-1:0] tot_sum;
    logic [SQ_WIDTH-1:0]        tot_sq;

    // Lowest free bank is taken at the first beat of a group
    assign pick_bank = bank_free[0] ? 1'b0 : 1'b1;

    // Mid-group the bank is already owned; a new group needs a free bank
    // and the previous totals taken by the statistics block
    assign in_ready  = !sums_valid && ((beat_cnt != '0) || (|bank_free));
    assign wr_en     = in_valid && in_ready;
    assign wr_bank   = (beat_cnt == '0) ? pick_bank : cur_bank;
    assign wr_beat   = beat_cnt;
    assign wr_data   = in_data;
    assign last_beat = (beat_cnt == BEAT_IDX_WIDTH'(BEATS - 1));
    assign fill_done = wr_en && last_beat;

    // Lane sum and sum of squares of the incoming beat
    always_comb begin
        beat_sum = '0;
        beat_sq  = '0;
        for (int i = 0; i < LANES; i++) begin
            lane     = signed'(in_data[i*IN_WIDTH +: IN_WIDTH]);
            lane_sq  = lane * lane;
            beat_sum = beat_sum + SUM_WIDTH'(lane);
            beat_sq  = beat_sq + SQ_WIDTH'(lane_sq);
        end
    end

    // First beat restarts the running totals
    assign tot_sum = ((beat_cnt == '0) ? '0 : acc_sum) + beat_sum;
    assign tot_sq  = ((beat_cnt == '0) ? '0 : acc_sq) + beat_sq;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt   <= '0;
            sums_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
            if (fill_done) begin
                sums_valid <= 1'b1;
            end else if (sums_ready) begin
                sums_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            cur_bank <= wr_bank;
            acc_sum  <= tot_sum;
            acc_sq   <= tot_sq;
        end
        if (fill_done) begin
            sum_data   <= tot_sum;
            sq_data    <= tot_sq;
            stats_bank <= wr_bank;
        end
    end

endmodule

// File: source/group_norm_top.sv
// Top level of the streaming group-normalization engine
// Loader, two-bank group buffer, statistics stage and emitter
`timescale 1ns/1ns

module group_norm_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [gn_pkg::BEAT_WIDTH-1:0]     in_data,
    input  logic                              in_valid,
    output logic                              in_ready,
    output logic [gn_pkg::OUT_BEAT_WIDTH-1:0] out_data,
    output logic                              out_valid,
    input  logic                              out_ready
);
    import gn_pkg::*;

    logic                        wr_en;
    logic                        wr_bank;
    logic [BEAT_IDX_WIDTH-1:0]   wr_beat;
    logic [BEAT_WIDTH-1:0]       wr_data;
    logic                        fill_done;
    logic [NUM_BANKS-1:0]        bank_free;
    logic                        rd_bank;
    logic [BEAT_IDX_WIDTH-1:0]   rd_beat;
    logic [BEAT_WIDTH-1:0]       rd_data;
    logic                        drain_done;

    logic signed [SUM_WIDTH-1:0] sum_data;
    logic [SQ_WIDTH-1:0]         sq_data;
    logic                        sums_valid;
    logic                        sums_ready;
    logic                        loader_bank;

    logic signed [SUM_WIDTH-1:0] stats_sum;
    logic [INV_WIDTH-1:0]        stats_inv;
    logic                        stats_valid;
    logic                        stats_ready;
    logic                        stats_bank;

    group_loader i_loader (
        .clk        (clk),
        .rst        (rst),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .bank_free  (bank_free),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_beat    (wr_beat),
        .wr_data    (wr_data),
        .fill_done  (fill_done),
        .sum_data   (sum_data),
        .sq_data    (sq_data),
        .sums_valid (sums_valid),
        .sums_ready (sums_ready),
        .stats_bank (loader_bank)
    );

    group_bank_buffer i_buffer (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_beat    (wr_beat),
        .wr_data    (wr_data),
        .fill_done  (fill_done),
        .rd_bank    (rd_bank),
        .rd_beat    (rd_beat),
        .rd_data    (rd_data),
        .drain_done (drain_done),
        .bank_free  (bank_free)
    );

    group_stats i_stats (
        .clk         (clk),
        .rst         (rst),
        .sum_data    (sum_data),
        .sq_data     (sq_data),
        .sums_valid  (sums_valid),
        .sums_ready  (sums_ready),
        .bank_in     (loader_bank),
        .sum_out     (stats_sum),
        .inv_data    (stats_inv),
        .stats_valid (stats_valid),
        .stats_ready (stats_ready),
        .bank_out    (stats_bank)
    );

    norm_emitter i_emitter (
        .clk         (clk),
        .rst         (rst),
        .sum_in      (stats_sum),
        .inv_in      (stats_inv),
        .bank_in     (stats_bank),
        .stats_valid (stats_valid),
        .stats_ready (stats_ready),
        .rd_bank     (rd_bank),
        .rd_beat     (rd_beat),
        .rd_data     (rd_data),
        .drain_done  (drain_done),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

// File: source/group_stats.sv
// Statistics stage of the group-normalization engine
// Variance from the group sum and sum of squares
// Bit-serial inverse square root, one result bit per cycle
// Holds S, r and the bank index until the emitter takes them
`timescale 1ns/1ns

module group_stats (
    input  logic                                clk,
    input  logic                                rst,
    input  logic signed [gn_pkg::SUM_WIDTH-1:0] sum_data,
    input  logic [gn_pkg::SQ_WIDTH-1:0]         sq_data,
    input  logic                                sums_valid,
    output logic                                sums_ready,
    input  logic                                bank_in,
    output logic signed [gn_pkg::SUM_WIDTH-1:0] sum_out,
    output logic [gn_pkg::INV_WIDTH-1:0]        inv_data,
    output logic                                stats_valid,
    input  logic                                stats_ready,
    output logic                                bank_out
);
    import gn_pkg::*;

    stats_state_t                        state;
    logic signed [SUM_WIDTH-1:0]         s_reg;
    logic [SQ_WIDTH-1:0]                 q_reg;
    logic                                bank_reg;
    logic [VAR_WIDTH-1:0]                var_reg;
    logic [INV_WIDTH-1:0]                inv_reg;
    logic [$clog2(INV_WIDTH)-1:0]        bit_idx;
    logic signed [SQ_WIDTH+GROUP_SHIFT+1:0] var_diff;
    logic [INV_WIDTH-1:0]                trial;
    logic [2*INV_WIDTH+VAR_WIDTH-1:0]    root_prod;
    logic                                keep;

    assign sums_ready  = (state == S_IDLE);
    assign stats_valid = (state == S_HOLD);
    assign sum_out     = s_reg;
    assign inv_data    = inv_reg;
    assign bank_out    = bank_reg;

    // 16*Q - S*S is never negative, so the shift by 8 is a plain floor
    assign var_diff = ($signed({1'b0, q_reg}) <<< GROUP_SHIFT) - s_reg * s_reg;

    // Trial bit kept when trial^2 * var stays within 2^20
    assign trial     = inv_reg | (INV_WIDTH'(1) << bit_idx);
    assign root_prod = trial * trial * var_reg;
    assign keep      = root_prod <= ((2*INV_WIDTH+VAR_WIDTH)'(1) << INV_TARGET_SHIFT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (sums_valid) begin
                        state <= S_VAR;
                    end
                end
                S_VAR: begin
                    state <= S_ROOT;
                end
                S_ROOT: begin
                    if (bit_idx == '0) begin
                        state <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    if (stats_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && sums_valid) begin
            s_reg    <= sum_data;
            q_reg    <= sq_data;
            bank_reg <= bank_in;
        end
        if (state == S_VAR) begin
            var_reg <= var_diff[2*GROUP_SHIFT +: VAR_WIDTH];
            inv_reg <= '0;
            bit_idx <= $bits(bit_idx)'(INV_WIDTH - 1);
        end
        if (state == S_ROOT) begin
            if (keep) begin
                inv_reg <= trial;
            end
            bit_idx <= bit_idx - 1'b1;
        end
    end

endmodule

// File: source/norm_emitter.sv
// Output side of the group-normalization engine
// Replays the stored beats of a group from its bank
// Per lane: (16*x - S) * r, floor shift, saturation to Q3.4
// Output register with valid/ready, frees the bank after the last beat
`timescale 1ns/1ns

module norm_emitter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic signed [gn_pkg::SUM_WIDTH-1:0] sum_in,
    input  logic [gn_pkg::INV_WIDTH-1:0]        inv_in,
    input  logic                                bank_in,
    input  logic                                stats_valid,
    output logic                                stats_ready,
    output logic                                rd_bank,
    output logic [gn_pkg::BEAT_IDX_WIDTH-1:0]   rd_beat,
    input  logic [gn_pkg::BEAT_WIDTH-1:0]       rd_data,
    output logic                                drain_done,
    output logic [gn_pkg::OUT_BEAT_WIDTH-1:0]   out_data,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import gn_pkg::*;

    logic                        active;
    logic signed [SUM_WIDTH-1:0] s_reg;
    logic [INV_WIDTH-1:0]        r_reg;
    logic                        bank_reg;
    // Counts up to BEATS, so one bit wider than the beat index
    logic [BEAT_IDX_WIDTH:0]     rd_cnt;
    logic [BEAT_IDX_WIDTH-1:0]   out_cnt;
    logic                        load;
    logic [OUT_BEAT_WIDTH-1:0]   next_out;

    // A new group starts only after the previous one is fully drained
    assign stats_ready = !active;
    assign rd_bank     = bank_reg;
    assign rd_beat     = rd_cnt[BEAT_IDX_WIDTH-1:0];
    assign load        = active && (rd_cnt != (BEAT_IDX_WIDTH+1)'(BEATS))
                         && (!out_valid || out_ready);
    assign drain_done  = out_valid && out_ready
                         && (out_cnt == BEAT_IDX_WIDTH'(BEATS - 1));

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic signed [IN_WIDTH-1:0]              x;
        logic signed [SUM_WIDTH:0]               diff;
        logic signed [SUM_WIDTH+INV_WIDTH+1:0]   prod;
        logic signed [SUM_WIDTH+INV_WIDTH+1:0]   scaled;

        assign x      = signed'(rd_data[l*IN_WIDTH +: IN_WIDTH]);
        assign diff   = (x <<< GROUP_SHIFT) - s_reg;
        assign prod   = diff * $signed({1'b0, r_reg});
        // Arithmetic shift gives floor for negative products
        assign scaled = prod >>> NORM_SHIFT;
        assign next_out[l*OUT_WIDTH +: OUT_WIDTH] =
            (scaled > OUT_MAX) ? OUT_WIDTH'(OUT_MAX) :
            (scaled < OUT_MIN) ? OUT_WIDTH'(OUT_MIN) :
            scaled[OUT_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            out_valid <= 1'b0;
            rd_cnt    <= '0;
            out_cnt   <= '0;
        end else begin
            if (stats_valid && stats_ready) begin
                active  <= 1'b1;
                rd_cnt  <= '0;
                out_cnt <= '0;
            end else begin
                if (load) begin
                    rd_cnt <= rd_cnt + 1'b1;
                end
                if (out_valid && out_ready) begin
                    out_cnt <= out_cnt + 1'b1;
                end
                if (drain_done) begin
                    active <= 1'b0;
                end
            end
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stats_valid && stats_ready) begin
            s_reg    <= sum_in;
            r_reg    <= inv_in;
            bank_reg <= bank_in;
        end
        if (load) begin
            out_data <= next_out;
        end
    end

endmodule

// File: testbench/group_norm_vectors.txt
// Columns: in_data, expected out_data; four 8-bit lanes each, lane 0 in the low byte
// Inputs are Q5.2, outputs are Q3.4; four lines per group, eight groups
// Group 0: all lanes equal, zero variance
05050505 00000000
05050505 00000000
05050505 00000000
05050505 00000000
// Group 1: flat group with a +3 and a -2 outlier, saturates at 127 and -128
0A0A0A0D FCFCFC7F
0A0A0A0A FCFCFCFC
080A0A0A 80FCFCFC
0A0A0A0A FCFCFCFC
// Group 2: +3 and -3, zero mean
FD03FD03 F00FF00F
03FD03FD 0FF00FF0
FDFD0303 F0F00F0F
0303FDFD 0F0FF0F0
// Group 3: ramp 0 to 15
03020100 F0ECE9E5
07060504 FEFAF7F3
0B0A0908 0C080501
0F0E0D0C 1A16130F
// Group 4: ramp 0 down to -30
FAFCFE00 0F13161A
F2F4F6F8 0105080C
EAECEEF0 F3F7FAFE
E2E4E6E8 E5E9ECF0
// Group 5: +120 and -120, large variance
78787878 0F0F0F0F
88888888 F1F1F1F1
88788878 F10FF10F
78887888 0FF10FF1
// Group 6: mixed values
0021F914 FA1DF30F
0905F10C 03FFEA07
1B0112E2 16FB0DDB
FE060BFC F80006F6
// Group 7: flat negative group with one outlier
CECECECE F0F0F0F0
CECECECE F0F0F0F0
CECECECE F0F0F0F0
CECED2CE F0F07FF0

// File: testbench/tb_group_norm.sv
// Self-checking testbench for the group-normalization engine
// Reads input beats and expected output beats from the vector file
// Driver offers groups with random gaps, then back-to-back
// Monitor randomizes out_ready, stalls the output twice and checks every beat in order
`timescale 1ns/1ns

module tb_group_norm;
    import gn_pkg::*;

    localparam int NUM_GROUPS   = 8;
    localparam int NUM_BEATS    = NUM_GROUPS * BEATS;
    localparam int WAIT_LIMIT   = 300;
    localparam int STALL_CYCLES = 60;

    logic                      clk;
    logic                      rst;
    logic [BEAT_WIDTH-1:0]     in_data;
    logic                      in_valid;
    logic                      in_ready;
    logic [OUT_BEAT_WIDTH-1:0] out_data;
    logic                      out_valid;
    logic                      out_ready;

    // Two words per beat: input beat, then expected output beat
    logic [31:0] vectors [0:2*NUM_BEATS-1];
    integer      seed;
    int          groups_sent;
    int          max_in_wait;

    group_norm_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Called at a falling edge, returns at the falling edge after the transfer
    task automatic send_beat(input logic [BEAT_WIDTH-1:0] data);
        int waited;
        waited   = 0;
        in_data  = data;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                fail_run("Timeout: in_ready never rose for an offered input beat");
            end
        end
        if (waited > max_in_wait) begin
            max_in_wait = waited;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drive_groups();
        int gap;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int b = 0; b < BEATS; b++) begin
                // First half with idle gaps, second half streams back-to-back
                if (g < NUM_GROUPS / 2) begin
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) @(negedge clk);
                end
                send_beat(vectors[2*(g*BEATS+b)]);
            end
            groups_sent++;
        end
    endtask

    task automatic check_outputs();
        int          count;
        int          idle;
        int          stall_point;
        logic [31:0] expected;
        count       = 0;
        idle        = 0;
        stall_point = 16;
        while (count < NUM_BEATS) begin
            @(negedge clk);
            if (groups_sent == 0) begin
                assert (out_valid === 1'b0) else fail_run($sformatf(
                    "CHECK FAILED out_valid: got 0x%0h, expected 0x0 before any group",
                    out_valid));
            end
            // Long output stalls so both banks fill up
            if (count == stall_point) begin
                out_ready = 1'b0;
                repeat (STALL_CYCLES) @(negedge clk);
                stall_point = (stall_point == 16) ? 22 : -1;
            end
            if (count >= 24) begin
                out_ready = 1'b1;
            end else begin
                out_ready = ($unsigned($random(seed)) % 4) != 0;
            end
            if (out_valid && out_ready) begin
                expected = vectors[2*count+1];
                assert (out_data === expected) else fail_run($sformatf(
                    "CHECK FAILED out_data beat %0d: got 0x%08h, expected 0x%08h",
                    count, out_data, expected));
                count++;
                idle = 0;
            end else begin
                idle++;
                if (idle > WAIT_LIMIT) begin
                    fail_run($sformatf("Timeout: output beat %0d never arrived", count));
                end
            end
        end
    endtask

    initial begin
        seed        = 32'hacbf;
        rst         = 1'b1;
        in_data     = '0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        groups_sent = 0;
        max_in_wait = 0;
        $readmemh("testbench/group_norm_vectors.txt", vectors);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        fork
            drive_groups();
            check_outputs();
        join

        // A stalled output must have held off the input for a long stretch
        assert (max_in_wait >= 20) else fail_run(
            "Back-pressure missing: in_ready never stayed low while the output stalled");

        // No extra beats after the last group
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (out_valid === 1'b0) else fail_run($sformatf(
                "CHECK FAILED out_valid: got 0x%0h, expected 0x0 after the last beat",
                out_valid));
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule
